//--- bench/tb_mat_calc.sv
// ========================================
// serial output is checked byte by byte against a model of both slots
// writes and starts happen only while busy is low
// ========================================
module tb_mat_calc;
    timeunit 1ns;
    timeprecision 1ps;

    import mat_pkg::*;
    import uart_pkg::*;

    localparam int TIMEOUT_CYCLES = 250_000;   // 20 results of 110 bytes plus margin

    logic                clk;
    logic                sys_rst_n;
    logic                wr_en;
    slot_t               wr_slot;
    logic [DIM_W-1:0]    wr_row;
    logic [DIM_W-1:0]    wr_col;
    logic [ELEM_W-1:0]   wr_data;
    logic                start;
    op_e                 op;
    slot_t               slot_a;
    slot_t               slot_b;
    logic [DIM_W-1:0]    rows;
    logic [DIM_W-1:0]    cols;
    logic [SCALAR_W-1:0] scalar;
    logic                busy;
    logic                done;
    logic                uart_tx;
    logic                tx_busy;

    int         model [NUM_SLOTS][MAX_DIM][MAX_DIM];   // copy of the store
    logic [7:0] exp_q [$];
    logic [7:0] rx_q [$];
    int         errors;
    int         pass_count;
    int         fail_count;
    int         cycles;

    mat_calc_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // reference model
    // ========================================
    function automatic void push_decimal(input int v);
        if (v >= 100) exp_q.push_back(8'(48 + v / 100));
        if (v >= 10) exp_q.push_back(8'(48 + (v / 10) % 10));
        exp_q.push_back(8'(48 + v % 10));
    endfunction

    function automatic void expect_bytes(input op_e kind, input int sa, input int sb,
                                         input int n_rows, input int n_cols, input int k);
        int out_rows;
        int out_cols;
        int v;
        out_rows = (kind == OP_TRANSPOSE) ? n_cols : n_rows;
        out_cols = (kind == OP_TRANSPOSE) ? n_rows : n_cols;
        for (int r = 0; r < out_rows; r++) begin
            for (int c = 0; c < out_cols; c++) begin
                case (kind)
                    OP_ADD:       v = (model[sa][r][c] + model[sb][r][c]) % 256;
                    OP_TRANSPOSE: v = model[sa][c][r];
                    default:      v = (model[sa][r][c] * k) % 256;
                endcase
                push_decimal(v);
                exp_q.push_back(ASCII_SPACE);
                if (c == out_cols - 1) begin   // row end
                    exp_q.push_back(ASCII_CR);
                    exp_q.push_back(ASCII_LF);
                end
            end
        end
    endfunction

    // ========================================
    // stimulus helpers
    // ========================================
    task automatic write_elem(input int s, input int r, input int c, input int v);
        model[s][r][c] = v % 256;
        wr_slot = slot_t'(s);
        wr_row  = DIM_W'(r);
        wr_col  = DIM_W'(c);
        wr_data = ELEM_W'(v);
        wr_en   = 1'b1;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_op(input op_e kind, input int sa, input int sb,
                          input int n_rows, input int n_cols, input int k);
        expect_bytes(kind, sa, sb, n_rows, n_cols, k);
        op     = kind;
        slot_a = slot_t'(sa);
        slot_b = slot_t'(sb);
        rows   = DIM_W'(n_rows);
        cols   = DIM_W'(n_cols);
        scalar = SCALAR_W'(k);
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) @(negedge clk);
        @(negedge clk);   // done sits in the last busy cycle
        if (busy) begin
            errors++;
            $display("FAIL %0t: busy still high one cycle after done", $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (exp_q.size() != 0 || tx_busy) @(negedge clk);
        if (errors == errors_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // ========================================
    // serial monitor, samples mid-bit on the falling edge
    // ========================================
    initial begin : serial_monitor
        logic [7:0] shift;
        forever begin
            @(negedge clk);
            if (sys_rst_n === 1'b1 && uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                if (uart_tx !== 1'b0) begin
                    errors++;
                    $display("start bit did not hold low at %0t", $time);
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        shift = {uart_tx, shift[7:1]};   // lsb first
                    end
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    if (uart_tx !== 1'b1) begin
                        errors++;
                        $display("missing stop bit at %0t", $time);
                    end
                    rx_q.push_back(shift);
                end
            end
        end
    end

    initial begin : byte_compare
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(posedge clk);
            while (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected byte 0x%02h on the serial line at %0t", got, $time);
                end else begin
                    want = exp_q.pop_front();
                    if (got !== want) begin
                        errors++;
                        $display("FAIL %0t: byte expected 0x%02h received 0x%02h",
                                 $time, want, got);
                    end
                end
            end
        end
    end

    // run limit
    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, serial output never completed", cycles);
        $display("Testbench failed");
        $finish;
    end

    // ========================================
    // test sequence
    // ========================================
    initial begin : main
        int mark;
        op_e kind;
        sys_rst_n  = 1'b0;
        wr_en      = 1'b0;
        wr_slot    = '0;
        wr_row     = '0;
        wr_col     = '0;
        wr_data    = '0;
        start      = 1'b0;
        op         = OP_ADD;
        slot_a     = '0;
        slot_b     = '0;
        rows       = '0;
        cols       = '0;
        scalar     = '0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(32'h38f7_e3f6));
        for (int s = 0; s < NUM_SLOTS; s++)
            for (int r = 0; r < MAX_DIM; r++)
                for (int c = 0; c < MAX_DIM; c++)
                    model[s][r][c] = 0;

        repeat (4) @(posedge clk);   // four rising edges in reset
        @(negedge clk);
        sys_rst_n = 1'b1;
        @(negedge clk);

        mark = errors;
        check_bit("uart_tx", uart_tx, 1'b1);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("tx_busy", tx_busy, 1'b0);
        finish_test("reset", mark);

        // sums above 255 wrap
        mark = errors;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                write_elem(0, r, c, 200 + 10 * r + c);
                write_elem(1, r, c, 90 + 20 * r + 7 * c);
            end
        end
        run_op(OP_ADD, 0, 1, 3, 3, 0);
        finish_test("add 3x3", mark);

        mark = errors;
        for (int r = 0; r < 2; r++)
            for (int c = 0; c < 4; c++)
                write_elem(1, r, c, 3 + 50 * r + 11 * c);
        run_op(OP_TRANSPOSE, 1, 0, 2, 4, 0);
        finish_test("transpose 2x4", mark);

        // products of 1, 2 and 3 digits
        mark = errors;
        for (int r = 0; r < 5; r++)
            for (int c = 0; c < 5; c++)
                write_elem(0, r, c, ((r * 5 + c) * 11) % 256);
        run_op(OP_SCALAR, 0, 0, 5, 5, 15);
        finish_test("scalar 5x5", mark);

        mark = errors;
        run_op(OP_ADD, 0, 1, 3, 3, 0);
        run_op(OP_SCALAR, 1, 0, 3, 3, 7);   // first result still on the line
        finish_test("back to back", mark);

        for (int i = 0; i < 12; i++) begin
            mark = errors;
            for (int s = 0; s < NUM_SLOTS; s++)
                for (int r = 0; r < MAX_DIM; r++)
                    for (int c = 0; c < MAX_DIM; c++)
                        write_elem(s, r, c, $urandom % 256);
            kind = op_e'($urandom % 3);
            run_op(kind, $urandom % 2, $urandom % 2, 1 + $urandom % 5, 1 + $urandom % 5,
                   $urandom % 16);
            finish_test($sformatf("random %0d (%s)", i, kind.name()), mark);
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- common/mat_pkg.sv
// ========================================
// matrix sizes are compile-time, 5x5 max, 8-bit unsigned elements
// ========================================
package mat_pkg;

    // ========================================
    // dimensions and widths
    // ========================================
    localparam int MAX_DIM   = 5;   // rows or cols, 1..5
    localparam int DIM_W     = 3;
    localparam int ELEM_W    = 8;
    localparam int SCALAR_W  = 4;   // scalar 0..15
    localparam int NUM_SLOTS = 2;

    typedef logic [0:0] slot_t;

    // engine operations
    typedef enum logic [1:0] {
        OP_ADD       = 2'd0,
        OP_TRANSPOSE = 2'd1,
        OP_SCALAR    = 2'd2
    } op_e;

endpackage

//--- common/uart_pkg.sv
// ========================================
// 8 clocks per bit suits simulation only, set for the board clock
// ========================================
package uart_pkg;

    localparam int CLKS_PER_BIT = 8;

    // ========================================
    // queue depths
    // ========================================
    localparam int RES_DEPTH  = 32;   // holds one whole 5x5 result
    localparam int BYTE_DEPTH = 64;

    // separators and digit base
    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_CR    = 8'h0D;
    localparam logic [7:0] ASCII_LF    = 8'h0A;

endpackage

//--- engine/mat_engine.sv
// ========================================
// one element per 3 or 4 clocks, never stalled, start only when idle
// ========================================
module mat_engine (
    input  logic                         clk,
    input  logic                         sys_rst_n,
    input  logic                         start,
    input  mat_pkg::op_e                 op,
    input  mat_pkg::slot_t               slot_a,
    input  mat_pkg::slot_t               slot_b,
    input  logic [mat_pkg::DIM_W-1:0]    rows,
    input  logic [mat_pkg::DIM_W-1:0]    cols,
    input  logic [mat_pkg::SCALAR_W-1:0] scalar,
    input  logic [mat_pkg::ELEM_W-1:0]   rd_data,
    output logic                         busy,
    output logic                         done,
    output logic                         rd_en,
    output mat_pkg::slot_t               rd_slot,
    output logic [mat_pkg::DIM_W-1:0]    rd_row,
    output logic [mat_pkg::DIM_W-1:0]    rd_col,
    output logic                         res_valid,
    output logic [mat_pkg::ELEM_W-1:0]   res_elem,
    output logic                         res_row_end
);
    import mat_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_RD_B,
        S_WAIT,
        S_EMIT
    } state_e;

    state_e                     state;
    op_e                        op_q;
    slot_t                      slot_a_q;
    slot_t                      slot_b_q;
    logic [DIM_W-1:0]           rows_q;
    logic [DIM_W-1:0]           cols_q;
    logic [SCALAR_W-1:0]        scalar_q;
    logic [DIM_W-1:0]           out_row;     // output position
    logic [DIM_W-1:0]           out_col;
    logic [DIM_W-1:0]           out_rows;
    logic [DIM_W-1:0]           out_cols;
    logic                       is_trans;
    logic                       row_end;
    logic                       last_elem;
    logic [ELEM_W-1:0]          opnd_a;
    logic [ELEM_W+SCALAR_W-1:0] product;
    logic [ELEM_W-1:0]          result;

    assign is_trans  = (op_q == OP_TRANSPOSE);
    assign out_rows  = is_trans ? cols_q : rows_q;
    assign out_cols  = is_trans ? rows_q : cols_q;
    assign row_end   = (out_col == out_cols - DIM_W'(1));
    assign last_elem = row_end && (out_row == out_rows - DIM_W'(1));

    // ========================================
    // store read port
    // ========================================
    assign busy    = (state != S_IDLE);
    assign rd_en   = (state == S_RD_A) || (state == S_RD_B);
    assign rd_slot = (state == S_RD_B) ? slot_b_q : slot_a_q;
    assign rd_row  = is_trans ? out_col : out_row;   // swapped index for transpose
    assign rd_col  = is_trans ? out_row : out_col;

    assign product = rd_data * scalar_q;

    // rd_data holds B for add, A otherwise
    always_comb begin
        case (op_q)
            OP_ADD:    result = opnd_a + rd_data;       // wraps mod 256
            OP_SCALAR: result = product[ELEM_W-1:0];
            default:   result = rd_data;
        endcase
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state     <= S_IDLE;
            op_q      <= OP_ADD;
            slot_a_q  <= '0;
            slot_b_q  <= '0;
            rows_q    <= '0;
            cols_q    <= '0;
            scalar_q  <= '0;
            out_row   <= '0;
            out_col   <= '0;
            done      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            done      <= 1'b0;
            res_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        op_q     <= op;
                        slot_a_q <= slot_a;
                        slot_b_q <= slot_b;
                        rows_q   <= rows;
                        cols_q   <= cols;
                        scalar_q <= scalar;
                        out_row  <= '0;
                        out_col  <= '0;
                        state    <= S_RD_A;
                    end
                end
                S_RD_A: state <= (op_q == OP_ADD) ? S_RD_B : S_WAIT;
                S_RD_B: state <= S_WAIT;
                S_WAIT: begin
                    res_valid <= 1'b1;
                    done      <= last_elem;   // lands in the last busy cycle
                    state     <= S_EMIT;
                end
                S_EMIT: begin
                    if (row_end) begin
                        out_col <= '0;
                        out_row <= out_row + 1'b1;
                    end else begin
                        out_col <= out_col + 1'b1;
                    end
                    state <= last_elem ? S_IDLE : S_RD_A;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_RD_B) opnd_a <= rd_data;   // A arrives while B is read
        if (state == S_WAIT) begin
            res_elem    <= result;
            res_row_end <= row_end;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!sys_rst_n)
        start |-> !busy);

    a_dims: assert property (@(posedge clk) disable iff (!sys_rst_n)
        start |-> rows >= 1 && rows <= MAX_DIM && cols >= 1 && cols <= MAX_DIM);

endmodule

//--- hdl/mat_calc_top.sv
// ========================================
// write matrices only while busy is low
// ========================================
module mat_calc_top (
    input  logic                         clk,
    input  logic                         sys_rst_n,
    input  logic                         wr_en,
    input  mat_pkg::slot_t               wr_slot,
    input  logic [mat_pkg::DIM_W-1:0]    wr_row,
    input  logic [mat_pkg::DIM_W-1:0]    wr_col,
    input  logic [mat_pkg::ELEM_W-1:0]   wr_data,
    input  logic                         start,
    input  mat_pkg::op_e                 op,
    input  mat_pkg::slot_t               slot_a,
    input  mat_pkg::slot_t               slot_b,
    input  logic [mat_pkg::DIM_W-1:0]    rows,
    input  logic [mat_pkg::DIM_W-1:0]    cols,
    input  logic [mat_pkg::SCALAR_W-1:0] scalar,
    output logic                         busy,
    output logic                         done,
    output logic                         uart_tx,
    output logic                         tx_busy
);

    // store read port
    logic                       rd_en;
    mat_pkg::slot_t             rd_slot;
    logic [mat_pkg::DIM_W-1:0]  rd_row;
    logic [mat_pkg::DIM_W-1:0]  rd_col;
    logic [mat_pkg::ELEM_W-1:0] rd_data;
    // result strobes
    logic                       res_valid;
    logic [mat_pkg::ELEM_W-1:0] res_elem;
    logic                       res_row_end;
    // byte queue
    logic                       push;
    logic [7:0]                 push_data;
    logic                       full;
    logic                       pop;
    logic [7:0]                 pop_data;
    logic                       empty;

    mat_store u_store (
        .clk      (clk),
        .sys_rst_n(sys_rst_n),
        .wr_en    (wr_en),
        .wr_slot  (wr_slot),
        .wr_row   (wr_row),
        .wr_col   (wr_col),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_slot  (rd_slot),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_data  (rd_data)
    );

    mat_engine u_engine (
        .clk        (clk),
        .sys_rst_n  (sys_rst_n),
        .start      (start),
        .op         (op),
        .slot_a     (slot_a),
        .slot_b     (slot_b),
        .rows       (rows),
        .cols       (cols),
        .scalar     (scalar),
        .rd_data    (rd_data),
        .busy       (busy),
        .done       (done),
        .rd_en      (rd_en),
        .rd_slot    (rd_slot),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .res_valid  (res_valid),
        .res_elem   (res_elem),
        .res_row_end(res_row_end)
    );

    dec_fmt u_fmt (
        .clk        (clk),
        .sys_rst_n  (sys_rst_n),
        .res_valid  (res_valid),
        .res_elem   (res_elem),
        .res_row_end(res_row_end),
        .full       (full),
        .push       (push),
        .push_data  (push_data)
    );

    byte_fifo u_fifo (
        .clk      (clk),
        .sys_rst_n(sys_rst_n),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .pop_data (pop_data),
        .full     (full),
        .empty    (empty)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .sys_rst_n(sys_rst_n),
        .empty    (empty),
        .pop_data (pop_data),
        .pop      (pop),
        .uart_tx  (uart_tx),
        .tx_busy  (tx_busy)
    );

endmodule

//--- hdl/mat_store.sv
// ========================================
// no collision check, write only while the engine is idle
// ========================================
module mat_store (
    input  logic                       clk,
    input  logic                       sys_rst_n,
    input  logic                       wr_en,
    input  mat_pkg::slot_t             wr_slot,
    input  logic [mat_pkg::DIM_W-1:0]  wr_row,
    input  logic [mat_pkg::DIM_W-1:0]  wr_col,
    input  logic [mat_pkg::ELEM_W-1:0] wr_data,
    input  logic                       rd_en,
    input  mat_pkg::slot_t             rd_slot,
    input  logic [mat_pkg::DIM_W-1:0]  rd_row,
    input  logic [mat_pkg::DIM_W-1:0]  rd_col,
    output logic [mat_pkg::ELEM_W-1:0] rd_data
);
    import mat_pkg::*;

    localparam int SLOT_SIZE = MAX_DIM * MAX_DIM;
    localparam int DEPTH     = NUM_SLOTS * SLOT_SIZE;
    localparam int ADDR_W    = $clog2(DEPTH);

    logic [ELEM_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // slot, row, col flattened row-major
    assign wr_addr = ADDR_W'(wr_slot * SLOT_SIZE + wr_row * MAX_DIM + wr_col);
    assign rd_addr = ADDR_W'(rd_slot * SLOT_SIZE + rd_row * MAX_DIM + rd_col);

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];   // valid one cycle after rd_en
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (!sys_rst_n)
        (wr_en |-> wr_row < MAX_DIM && wr_col < MAX_DIM) and
        (rd_en |-> rd_row < MAX_DIM && rd_col < MAX_DIM));

endmodule

//--- src.f
common/mat_pkg.sv
common/uart_pkg.sv
hdl/mat_store.sv
engine/mat_engine.sv
tx/dec_fmt.sv
tx/byte_fifo.sv
tx/uart_tx.sv
hdl/mat_calc_top.sv
bench/tb_mat_calc.sv

//--- tx/byte_fifo.sv
// ========================================
// head is shown on pop_data, no push when full, no pop when empty
// ========================================
module byte_fifo (
    input  logic       clk,
    input  logic       sys_rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);
    import uart_pkg::*;

    localparam int PTR_W = $clog2(BYTE_DEPTH);

    logic [7:0]       mem [BYTE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    assign pop_data = mem[rd_ptr];
    assign full     = (count == BYTE_DEPTH);
    assign empty    = (count == '0);

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!sys_rst_n)
        (push |-> !full) and (pop |-> !empty));

endmodule

//--- tx/dec_fmt.sv
// ========================================
// result queue holds one whole result, a full byte queue stalls here
// ========================================
module dec_fmt (
    input  logic                       clk,
    input  logic                       sys_rst_n,
    input  logic                       res_valid,
    input  logic [mat_pkg::ELEM_W-1:0] res_elem,
    input  logic                       res_row_end,
    input  logic                       full,
    output logic                       push,
    output logic [7:0]                 push_data
);
    import mat_pkg::*;
    import uart_pkg::*;

    localparam int PTR_W = $clog2(RES_DEPTH);

    logic [ELEM_W-1:0] q_elem [RES_DEPTH];
    logic              q_row_end [RES_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic [ELEM_W-1:0] head;
    logic              take;         // pop one result entry
    logic              fmt_busy;
    logic [2:0]        step;         // 0-2 digits, 3 space, 4 CR, 5 LF
    logic [2:0]        last_step;
    logic [ELEM_W-1:0] val;
    logic              val_row_end;

    assign head      = q_elem[rd_ptr];
    assign take      = !fmt_busy && (count != '0);
    assign push      = fmt_busy && !full;
    assign last_step = val_row_end ? 3'd5 : 3'd3;

    always_comb begin
        case (step)
            3'd0:    push_data = ASCII_ZERO + val / 8'd100;
            3'd1:    push_data = ASCII_ZERO + (val % 8'd100) / 8'd10;
            3'd2:    push_data = ASCII_ZERO + val % 8'd10;
            3'd3:    push_data = ASCII_SPACE;
            3'd4:    push_data = ASCII_CR;
            default: push_data = ASCII_LF;
        endcase
    end

    // ========================================
    // result queue storage
    // ========================================
    always_ff @(posedge clk) begin
        if (res_valid) begin
            q_elem[wr_ptr]    <= res_elem;
            q_row_end[wr_ptr] <= res_row_end;
        end
        if (take) begin
            val         <= head;
            val_row_end <= q_row_end[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            fmt_busy <= 1'b0;
            step     <= '0;
        end else begin
            if (res_valid) wr_ptr <= wr_ptr + 1'b1;
            case ({res_valid, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
            if (take) begin
                rd_ptr   <= rd_ptr + 1'b1;
                fmt_busy <= 1'b1;
                // skip leading zeros
                if (head >= 8'd100) begin
                    step <= 3'd0;
                end else if (head >= 8'd10) begin
                    step <= 3'd1;
                end else begin
                    step <= 3'd2;
                end
            end else if (push) begin
                if (step == last_step) fmt_busy <= 1'b0;
                else step <= step + 1'b1;
            end
        end
    end

    a_res_no_overflow: assert property (@(posedge clk) disable iff (!sys_rst_n)
        res_valid |-> count < RES_DEPTH);

endmodule

//--- tx/uart_tx.sv
// ========================================
// 8N1, LSB first, bit period from CLKS_PER_BIT
// ========================================
module uart_tx (
    input  logic       clk,
    input  logic       sys_rst_n,
    input  logic       empty,
    input  logic [7:0] pop_data,
    output logic       pop,
    output logic       uart_tx,
    output logic       tx_busy
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] clk_cnt;    // clocks within a bit
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign pop     = (state == ST_IDLE) && !empty;
    assign tx_busy = pop || (state != ST_IDLE);

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            uart_tx <= 1'b1;   // line idles high
        end else begin
            clk_cnt <= (state == ST_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        uart_tx <= 1'b0;   // start bit
                        state   <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        uart_tx <= shift_q[0];
                        bit_idx <= '0;
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            uart_tx <= 1'b1;   // stop bit
                            state   <= ST_STOP;
                        end else begin
                            uart_tx <= shift_q[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) shift_q <= pop_data;
        else if (state == ST_DATA && bit_end) shift_q <= shift_q >> 1;
    end

endmodule
